// File: hdl/busCpuPkg.sv
package busCpuPkg;

	localparam int dataWidth = 32;
	localparam int addrWidth = 16;
	localparam int regCount = 16;
	localparam int constWidth = 18;
	localparam int opcodeWidth = 5;

	// Low bit of each register field in the instruction word.
	localparam int raLsb = 23;
	localparam int rbLsb = 19;
	localparam int rcLsb = 15;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [addrWidth-1:0] memAddr_t;
	typedef logic [$clog2(regCount)-1:0] regIndex_t;

	// The opcode also selects the ALU operation.
	typedef enum logic [opcodeWidth-1:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opAddi = 5'd12,
		opOut = 5'd22,
		opHalt = 5'd27
	} opcode_t;

	typedef enum logic [3:0] {
		stReset,
		stT0,
		stT1,
		stT2,
		stT3,
		stT4,
		stT5,
		stT6,
		stT7,
		stHalted
	} seqState_t;

	typedef struct packed {
		logic pcOut;
		logic zOut;
		logic mdrOut;
		logic regOut;
		logic baOut;
		logic constOut;
		logic selA;
		logic selB;
		logic selC;
		logic regIn;
		logic yIn;
		logic zIn;
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic outIn;
		logic incPc;
		logic memRead;
		logic memWrite;
	} ctrlWord_t;

	typedef struct packed {
		memAddr_t addr;
		logic write;
		word_t wdata;
	} memReq_t;

endpackage

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	input ctrlWord_t ctrl,
	input word_t ir,
	input word_t busIn,
	output word_t regData
);

	word_t regs [regCount];
	regIndex_t regIndex;

	// Gra, Grb and Grc pick which instruction field names the register.
	always_comb begin
		if (ctrl.selA) begin
			regIndex = ir[raLsb +: $bits(regIndex_t)];
		end else if (ctrl.selB) begin
			regIndex = ir[rbLsb +: $bits(regIndex_t)];
		end else if (ctrl.selC) begin
			regIndex = ir[rcLsb +: $bits(regIndex_t)];
		end else begin
			regIndex = '0;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regIn) begin
			regs[regIndex] <= busIn;
		end
	end

	// With BAout, register 0 reads as zero so it can act as an absolute base.
	assign regData = (ctrl.baOut && regIndex == '0) ? '0 : regs[regIndex];

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	input ctrlWord_t ctrl,
	input opcode_t op,
	input word_t busIn,
	output word_t zData
);

	word_t yReg;
	word_t zReg;
	word_t result;

	always_comb begin
		if (ctrl.incPc) begin
			result = busIn + 1'b1;
		end else begin
			case (op)
				opSub: result = yReg - busIn;
				opAnd: result = yReg & busIn;
				opOr: result = yReg | busIn;
				// Address arithmetic and the immediate forms all add.
				default: result = yReg + busIn;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			yReg <= '0;
			zReg <= '0;
		end else begin
			if (ctrl.yIn) begin
				yReg <= busIn;
			end
			if (ctrl.zIn) begin
				zReg <= result;
			end
		end
	end

	assign zData = zReg;

endmodule

// File: hdl/memoryInterface.sv
`timescale 1ns/1ps

module memoryInterface import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	input ctrlWord_t ctrl,
	input word_t busIn,
	output word_t mdrData,
	output logic memDone,
	output logic memValid,
	output memReq_t memReq,
	input logic memReady,
	input logic rspValid,
	input word_t rdata
);

	memAddr_t mar;
	word_t mdr;
	logic reqPending;
	logic rspPending;
	logic isWrite;

	// A new access starts only when nothing is in flight, so a strobe that
	// stays high while the sequencer waits does not launch a second one.
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			reqPending <= 1'b0;
			rspPending <= 1'b0;
			isWrite <= 1'b0;
		end else if (!reqPending && !rspPending && (ctrl.memRead || ctrl.memWrite)) begin
			reqPending <= 1'b1;
			isWrite <= ctrl.memWrite;
		end else if (reqPending && memReady) begin
			reqPending <= 1'b0;
			rspPending <= 1'b1;
		end else if (rspPending && rspValid) begin
			rspPending <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.marIn) begin
			mar <= busIn[addrWidth-1:0];
		end
		if (ctrl.mdrIn) begin
			mdr <= busIn;
		end else if (memDone && !isWrite) begin
			mdr <= rdata;
		end
	end

	// The response completes the access in the same cycle the MDR is written.
	assign memDone = rspPending && rspValid;
	assign memValid = reqPending;
	assign memReq = '{addr: mar, write: isWrite, wdata: mdr};
	assign mdrData = mdr;

endmodule

// File: hdl/busDatapath.sv
`timescale 1ns/1ps

module busDatapath import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	input ctrlWord_t ctrl,
	output opcode_t opcode,
	output logic memDone,
	output logic outTaken,
	output logic memValid,
	output memReq_t memReq,
	input logic memReady,
	input logic rspValid,
	input word_t rdata,
	output logic outValid,
	output word_t outData,
	input logic outReady
);

	word_t busData;
	word_t ir;
	memAddr_t pc;
	word_t regData;
	word_t zData;
	word_t mdrData;
	word_t constExt;

	registerFile regFile_i (
		.Clock(Clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.ir(ir),
		.busIn(busData),
		.regData(regData)
	);

	aluUnit alu_i (
		.Clock(Clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.op(opcode),
		.busIn(busData),
		.zData(zData)
	);

	memoryInterface memIf_i (
		.Clock(Clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.busIn(busData),
		.mdrData(mdrData),
		.memDone(memDone),
		.memValid(memValid),
		.memReq(memReq),
		.memReady(memReady),
		.rspValid(rspValid),
		.rdata(rdata)
	);

	assign constExt = {{(dataWidth - constWidth){ir[constWidth-1]}}, ir[constWidth-1:0]};
	assign opcode = opcode_t'(ir[dataWidth-1 -: opcodeWidth]);

	// Only one source drives the bus in any state.
	always_comb begin
		if (ctrl.pcOut) begin
			busData = {{(dataWidth - addrWidth){1'b0}}, pc};
		end else if (ctrl.zOut) begin
			busData = zData;
		end else if (ctrl.mdrOut) begin
			busData = mdrData;
		end else if (ctrl.regOut || ctrl.baOut) begin
			busData = regData;
		end else if (ctrl.constOut) begin
			busData = constExt;
		end else begin
			busData = '0;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (ctrl.pcIn) begin
				pc <= busData[addrWidth-1:0];
			end
			if (ctrl.irIn) begin
				ir <= busData;
			end
		end
	end

	// Outport holds its value until the consumer takes it.
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (outTaken) begin
			outValid <= 1'b0;
		end else if (ctrl.outIn) begin
			outValid <= 1'b1;
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.outIn && !outValid) begin
			outData <= busData;
		end
	end

	assign outTaken = outValid && outReady;

endmodule

// File: hdl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	input opcode_t opcode,
	input logic memDone,
	input logic outTaken,
	output ctrlWord_t ctrl,
	output logic halted
);

	seqState_t state;
	seqState_t nextState;
	logic immForm;
	logic regForm;
	logic isLd;
	logic isSt;

	// ld, ldi, st and addi all form Rb + C in T3 and T4.
	assign immForm = opcode inside {opLd, opLdi, opSt, opAddi};
	assign regForm = opcode inside {opAdd, opSub, opAnd, opOr};
	assign isLd = opcode == opLd;
	assign isSt = opcode == opSt;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stReset: nextState = stT0;
			stT0: nextState = stT1;
			stT1: nextState = memDone ? stT2 : stT1;
			stT2: nextState = stT3;
			stT3: begin
				if (immForm || regForm) begin
					nextState = stT4;
				end else if (opcode == opOut) begin
					nextState = outTaken ? stT0 : stT3;
				end else if (opcode == opHalt) begin
					nextState = stHalted;
				end else begin
					nextState = stT0;
				end
			end
			stT4: nextState = stT5;
			stT5: nextState = (isLd || isSt) ? stT6 : stT0;
			stT6: begin
				if (isLd) begin
					nextState = memDone ? stT7 : stT6;
				end else begin
					nextState = stT7;
				end
			end
			stT7: begin
				if (isSt) begin
					nextState = memDone ? stT0 : stT7;
				end else begin
					nextState = stT0;
				end
			end
			stHalted: nextState = stHalted;
			default: nextState = stT0;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (state)
			stT0: begin
				ctrl.pcOut = 1'b1;
				ctrl.marIn = 1'b1;
				ctrl.incPc = 1'b1;
				ctrl.zIn = 1'b1;
			end
			stT1: begin
				ctrl.zOut = 1'b1;
				ctrl.pcIn = 1'b1;
				ctrl.memRead = 1'b1;
			end
			stT2: begin
				ctrl.mdrOut = 1'b1;
				ctrl.irIn = 1'b1;
			end
			stT3: begin
				if (immForm || regForm) begin
					ctrl.selB = 1'b1;
					ctrl.baOut = immForm;
					ctrl.regOut = regForm;
					ctrl.yIn = 1'b1;
				end else if (opcode == opOut) begin
					ctrl.selA = 1'b1;
					ctrl.regOut = 1'b1;
					ctrl.outIn = 1'b1;
				end
			end
			stT4: begin
				ctrl.constOut = immForm;
				ctrl.selC = regForm;
				ctrl.regOut = regForm;
				ctrl.zIn = 1'b1;
			end
			stT5: begin
				ctrl.zOut = 1'b1;
				ctrl.marIn = isLd || isSt;
				ctrl.selA = !(isLd || isSt);
				ctrl.regIn = !(isLd || isSt);
			end
			stT6: begin
				ctrl.memRead = isLd;
				ctrl.selA = isSt;
				ctrl.regOut = isSt;
				ctrl.mdrIn = isSt;
			end
			stT7: begin
				ctrl.mdrOut = isLd;
				ctrl.selA = isLd;
				ctrl.regIn = isLd;
				ctrl.memWrite = isSt;
			end
			default: ctrl = '0;
		endcase
	end

	assign halted = state == stHalted;

endmodule

// File: hdl/busCpu.sv
`timescale 1ns/1ps

module busCpu import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	output logic memValid,
	output memReq_t memReq,
	input logic memReady,
	input logic rspValid,
	input word_t rdata,
	output logic outValid,
	output word_t outData,
	input logic outReady,
	output logic halted
);

	ctrlWord_t ctrl;
	opcode_t opcode;
	logic memDone;
	logic outTaken;

	controlSequencer seq_i (
		.Clock(Clock),
		.rstN(rstN),
		.opcode(opcode),
		.memDone(memDone),
		.outTaken(outTaken),
		.ctrl(ctrl),
		.halted(halted)
	);

	busDatapath dp_i (
		.Clock(Clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.opcode(opcode),
		.memDone(memDone),
		.outTaken(outTaken),
		.memValid(memValid),
		.memReq(memReq),
		.memReady(memReady),
		.rspValid(rspValid),
		.rdata(rdata),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

endmodule

// File: sim/busCpu_props.sv
`timescale 1ns/1ps

module busCpu_props import busCpuPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic memValid,
	input memReq_t memReq,
	input logic memReady,
	input logic outValid,
	input word_t outData,
	input logic outReady,
	input logic halted
);

	// A request waiting for memReady keeps its address and data.
	memHold: assert property (@(posedge Clock) disable iff (!rstN)
		memValid && !memReady |=> memValid && $stable(memReq))
		else $error("Memory request changed before it was accepted");

	outHold: assert property (@(posedge Clock) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("Out port value changed before it was taken");

	// Only reset leaves the halted state.
	haltSticky: assert property (@(posedge Clock)
		rstN && halted |=> halted)
		else $error("Halted output fell without reset");

	resetQuiet: assert property (@(posedge Clock)
		!rstN |=> !memValid && !outValid)
		else $error("Valid output high during reset");

endmodule

bind busCpu busCpu_props props_i (
	.Clock(Clock),
	.rstN(rstN),
	.memValid(memValid),
	.memReq(memReq),
	.memReady(memReady),
	.outValid(outValid),
	.outData(outData),
	.outReady(outReady),
	.halted(halted)
);

// File: sim/busCpu_tb.sv
`timescale 1ns/1ps

module busCpu_tb import busCpuPkg::*; ();

	logic Clock;
	logic rstN;
	logic memValid;
	memReq_t memReq;
	logic memReady;
	logic rspValid;
	word_t rdata;
	logic outValid;
	word_t outData;
	logic outReady;
	logic halted;

	word_t memory [0:(1 << addrWidth) - 1];
	word_t expectedOuts [$];
	memAddr_t finalAddrs [$];
	word_t finalWords [$];

	integer seed = 32'hf9b3;
	int valueErrors = 0;
	int otherErrors = 0;
	int outIndex = 0;
	int codeEnd = 0;
	int timeoutCycles = 0;
	logic dataLoaded = 1'b0;
	logic firstSeen = 1'b0;
	logic haltSeen = 1'b0;
	memAddr_t nextFetch = '0;
	logic rspOwed = 1'b0;
	logic [1:0] rspWait = '0;
	memAddr_t rspAddr = '0;

	busCpu busCpu_i (
		.Clock(Clock),
		.rstN(rstN),
		.memValid(memValid),
		.memReq(memReq),
		.memReady(memReady),
		.rspValid(rspValid),
		.rdata(rdata),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady),
		.halted(halted)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// Program words sit at consecutive addresses from 0, so codeEnd marks the fetch range.
	task automatic loadTestData();
		int fd;
		int code;
		logic [7:0] tag;
		logic [8*100-1:0] restOfLine;
		memAddr_t addr;
		word_t word;
		logic done;
		for (int a = 0; a < (1 << addrWidth); a++) begin
			memory[a] = {~memAddr_t'(a), memAddr_t'(a)};
		end
		fd = $fopen("sim/busCpu_testdata.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Cannot open the test data file sim/busCpu_testdata.txt");
		end else begin
			done = 1'b0;
			while (!done) begin
				code = $fscanf(fd, "%s", tag);
				if (code != 1) begin
					done = 1'b1;
				end else if (tag == "#") begin
					code = $fgets(restOfLine, fd);
				end else if (tag == "M") begin
					code = $fscanf(fd, "%h %h", addr, word);
					memory[addr] = word;
					if (addr == memAddr_t'(codeEnd)) begin
						codeEnd++;
					end
				end else if (tag == "O") begin
					code = $fscanf(fd, "%h", word);
					expectedOuts.push_back(word);
				end else if (tag == "S") begin
					code = $fscanf(fd, "%h %h", addr, word);
					finalAddrs.push_back(addr);
					finalWords.push_back(word);
				end else begin
					otherErrors++;
					$display("Unknown line tag in the test data file");
				end
			end
			$fclose(fd);
		end
	endtask

	// Memory model with random ready, random response delay and random out-port ready.
	always @(posedge Clock) begin
		logic [31:0] draw;
		draw = $random(seed);
		if (!rstN) begin
			memReady <= 1'b0;
			rspValid <= 1'b0;
			outReady <= 1'b0;
			rspOwed = 1'b0;
		end else begin
			memReady <= draw[0] | draw[1];
			outReady <= draw[8];
			rspValid <= 1'b0;
			if (memValid && memReady) begin
				rspOwed = 1'b1;
				rspWait = draw[5:4];
				rspAddr = memReq.addr;
				if (memReq.write) begin
					memory[memReq.addr] = memReq.wdata;
				end
			end
			if (rspOwed) begin
				if (rspWait == 2'd0) begin
					rspValid <= 1'b1;
					rdata <= memory[rspAddr];
					rspOwed = 1'b0;
				end else begin
					rspWait = rspWait - 2'd1;
				end
			end
		end
	end

	always @(posedge Clock) begin
		if (rstN) begin
			if (memValid && memReady) begin
				if (!firstSeen) begin
					assert (!memReq.write && memReq.addr == '0) else begin
						valueErrors++;
						$display("** Error first request: expected read at %h, actual %s at %h",
							16'h0000, memReq.write ? "write" : "read", memReq.addr);
					end
					firstSeen = 1'b1;
				end
				if (!memReq.write && memReq.addr < memAddr_t'(codeEnd)) begin
					assert (memReq.addr == nextFetch) else begin
						valueErrors++;
						$display("** Error fetch address: expected %h, actual %h",
							nextFetch, memReq.addr);
					end
					nextFetch = memReq.addr + 1'b1;
				end
			end
			if (outValid && outReady) begin
				assert (outIndex < expectedOuts.size()) else begin
					otherErrors++;
					$display("An extra out value %h appeared after all expected ones", outData);
				end
				if (outIndex < expectedOuts.size()) begin
					assert (outData == expectedOuts[outIndex]) else begin
						valueErrors++;
						$display("** Error out value %0d: expected %h, actual %h",
							outIndex, expectedOuts[outIndex], outData);
					end
					outIndex++;
				end
			end
			if (haltSeen) begin
				assert (halted) else begin
					otherErrors++;
					$display("The halted output dropped after the halt instruction");
				end
				assert (!memValid) else begin
					otherErrors++;
					$display("A memory request was issued after halt");
				end
				assert (!outValid) else begin
					otherErrors++;
					$display("An out value was offered after halt");
				end
			end
			if (halted) begin
				haltSeen = 1'b1;
			end
		end
	end

	initial begin
		wait (dataLoaded);
		repeat (timeoutCycles) @(posedge Clock);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		memReady = 1'b0;
		rspValid = 1'b0;
		rdata = '0;
		outReady = 1'b0;
		loadTestData();
		// Every instruction may wait four times longer than its unloaded latency.
		timeoutCycles = 40 * codeEnd * 4 + 8 + 50;
		dataLoaded = 1'b1;
		repeat (8) @(posedge Clock);
		rstN <= 1'b1;
		while (!halted) @(posedge Clock);
		repeat (50) @(posedge Clock);
		assert (outIndex == expectedOuts.size()) else begin
			otherErrors++;
			$display("Only %0d of %0d expected out values arrived", outIndex,
				expectedOuts.size());
		end
		foreach (finalAddrs[i]) begin
			assert (memory[finalAddrs[i]] == finalWords[i]) else begin
				valueErrors++;
				$display("** Error final memory word %h: expected %h, actual %h",
					finalAddrs[i], finalWords[i], memory[finalAddrs[i]]);
			end
		end
		$display("Checks done with %0d value errors and %0d other errors",
			valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: sim/busCpu_testdata.txt
# M addr word = memory image, O value = next expected out value
# S addr word = expected memory word after halt, all fields hex
M 0000 01000040
M 0001 09800042
M 0002 021BFFFF
M 0003 B1000000
M 0004 B2000000
M 0005 1A920000
M 0006 B2800000
M 0007 23120000
M 0008 B3000000
M 0009 2B920000
M 000A B3800000
M 000B 34120000
M 000C B4000000
M 000D 649BFFFB
M 000E B4800000
M 000F 1418000E
M 0010 D8000000
M 0040 12345678
M 0041 0F0F00FF
O 12345678
O 0F0F00FF
O 21435777
O 03255579
O 02040078
O 1F3F56FF
O 0000003D
S 0050 1F3F56FF
S 0040 12345678

// File: busCpu.f
hdl/busCpuPkg.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/memoryInterface.sv
hdl/busDatapath.sv
hdl/controlSequencer.sv
hdl/busCpu.sv
sim/busCpu_props.sv
sim/busCpu_tb.sv

// File: Makefile
SIM      = verilator
TOP      = busCpu_tb
FILELIST = busCpu.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
PASS     = All tests passed
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) sim/busCpu_testdata.txt
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
